/* filelist.f */
+incdir+dv
verilog/bpPkg.sv
verilog/syncFifo.sv
verilog/predBackupFile.sv
verilog/branchTargetBuffer.sv
verilog/gshareDirPredictor.sv
verilog/returnStack.sv
verilog/branchPredictor.sv
dv/bpTb.sv

/* run.sh */
#!/bin/bash
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module bpTb -o bpSim
./obj_dir/bpSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
    exit 1
fi
exit 0

/* dv/bpModel.svh */
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// Mirrors of the predictor state, advanced once per cycle by the testbench
logic mBtbValid [1 << BtbIdxW];
logic [BtbTagW-1:0] mBtbTag [1 << BtbIdxW];
BrKind mBtbKind [1 << BtbIdxW];
logic [PcW-1:0] mBtbTarget [1 << BtbIdxW];
logic [1:0] mCtr [1 << HistW];
logic [PcW-1:0] mStack [1 << RasDepthW];
logic [RasDepthW-1:0] mRasIdx;
logic [HistW-1:0] mHist;
logic [PcW-1:0] mPc;
logic [FetchIdW-1:0] mId;
logic mStarted;
logic mRecValid;
logic [HistW-1:0] mRecHist;
logic [RasDepthW-1:0] mRecRasIdx;
logic mTrainPending;
logic [PcW-1:0] mTrainPc;
logic [HistW-1:0] mTrainHist;
logic mTrainTaken;
BackupRec mSnap [1 << FetchIdW];
TgtUpdRec mTgtQ [$];
ResolveRec mResQ [$];

function automatic logic [HistW-1:0] shiftHist(input logic [HistW-1:0] h, input logic b);
    return {h[HistW-2:0], b};
endfunction

// Saturating two-bit counter step
function automatic logic [1:0] satCount(input logic [1:0] c, input logic taken);
    if (taken) begin
        return (c == 2'b11) ? c : c + 2'b01;
    end
    return (c == 2'b00) ? c : c - 2'b01;
endfunction

// Expected prediction for one fetch address
function automatic void predictNext(input logic [PcW-1:0] pc, input logic [HistW-1:0] hist,
                                    input logic [RasDepthW-1:0] rasIdx,
                                    output logic [PcW-1:0] npc, output logic taken,
                                    output logic hit, output BrKind kind);
    logic [BtbIdxW-1:0] idx;
    idx = pc[BtbIdxW-1:0];
    hit = mBtbValid[idx] && (mBtbTag[idx] == pc[BtbIdxW+BtbTagW-1:BtbIdxW]);
    kind = mBtbKind[idx];
    npc = pc + 1;
    taken = 1'b0;
    if (hit) begin
        if (kind == BrReturn) begin
            taken = 1'b1;
            npc = mStack[rasIdx];
        end else if (kind == BrJump || kind == BrCall) begin
            taken = 1'b1;
            npc = mBtbTarget[idx];
        end else begin
            taken = mCtr[pc[HistW-1:0] ^ hist][1];
            if (taken) begin
                npc = mBtbTarget[idx];
            end
        end
    end
endfunction

task automatic modelReset();
    for (int i = 0; i < (1 << BtbIdxW); i++) begin
        mBtbValid[i] = 1'b0;
    end
    for (int i = 0; i < (1 << HistW); i++) begin
        mCtr[i] = 2'b01;
    end
    mRasIdx = '0;
    mHist = '0;
    mPc = ResetPc;
    mId = '0;
    mStarted = 1'b0;
    mRecValid = 1'b0;
    mTrainPending = 1'b0;
    mTgtQ.delete();
    mResQ.delete();
endtask

`endif

/* dv/bpTb.sv */
`timescale 1ns/1ps

module bpTb import bpPkg::*; ();

    logic clk;
    logic rst;
    logic fetchValid;
    logic fetchReady;
    logic [PcW-1:0] fetchPc;
    logic [FetchIdW-1:0] fetchId;
    logic predTaken;
    BrKind predKind;
    logic predHit;
    logic [PcW-1:0] nextPc;
    logic tgtValid;
    logic [PcW-1:0] tgtPc;
    logic [PcW-1:0] tgtTarget;
    BrKind tgtKind;
    logic resolveValid;
    logic resolveReady;
    logic [FetchIdW-1:0] resolveId;
    logic resolveTaken;
    logic misprValid;
    logic [FetchIdW-1:0] misprId;
    logic misprTaken;
    logic [PcW-1:0] misprTarget;

    integer seed = 32'hbe00e994;
    int errors = 0;
    logic [FetchIdW-1:0] lastAcceptId;
    logic [PcW-1:0] watchPc;
    logic watchHit;
    logic [FetchIdW-1:0] watchId;

    `include "bpModel.svh"

    branchPredictor i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Test failures found");
        $finish;
    endtask

    // Model step and comparison, done mid-cycle where all inputs are settled
    always @(negedge clk) begin : modelStep
        logic [HistW-1:0] effHist;
        logic [RasDepthW-1:0] effRas;
        logic [PcW-1:0] expNext;
        logic expTaken;
        logic expHit;
        BrKind expKind;
        logic expCond;
        logic expValid;
        logic misprAct;
        logic acc;
        logic newTrain;
        logic tgtFull;
        logic resFull;
        BackupRec rd;
        if (rst) begin
            modelReset();
        end else begin
            effHist = mRecValid ? mRecHist : mHist;
            effRas = mRecValid ? mRecRasIdx : mRasIdx;
            predictNext(mPc, effHist, effRas, expNext, expTaken, expHit, expKind);
            expCond = expHit && expKind == BrCond;
            expValid = mStarted && !((mResQ.size() > 0 && mResQ[0].fetchId == mId)
                || (resolveValid && resolveId == mId));
            misprAct = misprValid && mStarted;
            acc = expValid && fetchReady && !misprAct;
            if (mStarted) begin
                check("fetchValid", fetchValid, expValid);
                check("fetchPc", fetchPc, mPc);
                check("fetchId", fetchId, mId);
                check("resolveReady", resolveReady, mResQ.size() != UpdQueueDepth);
            end
            if (acc) begin
                check("nextPc", nextPc, expNext);
                check("predTaken", predTaken, expTaken);
                check("predHit", predHit, expHit);
                if (expHit) begin
                    check("predKind", predKind, expKind);
                end
                lastAcceptId = mId;
                if (mPc == watchPc) begin
                    watchHit = 1'b1;
                    watchId = mId;
                end
            end
            if (mTrainPending) begin
                mCtr[mTrainPc[HistW-1:0] ^ mTrainHist] =
                    satCount(mCtr[mTrainPc[HistW-1:0] ^ mTrainHist], mTrainTaken);
            end
            // Single backup read, mispredict first
            newTrain = 1'b0;
            if (misprAct) begin
                rd = mSnap[misprId];
                mRecHist = rd.isCond ? shiftHist(rd.hist, misprTaken) : rd.hist;
                mRecRasIdx = rd.rasIdx;
            end else if (mStarted && mResQ.size() > 0) begin
                rd = mSnap[mResQ[0].fetchId];
                newTrain = 1'b1;
                mTrainPc = rd.pc;
                mTrainHist = rd.hist;
                mTrainTaken = mResQ[0].taken;
            end
            if (acc) begin
                mSnap[mId] = '{hist: effHist, rasIdx: effRas, pc: mPc, isCond: expCond,
                               predTaken: expTaken};
            end
            if (acc && expHit && expKind == BrCall) begin
                mStack[RasDepthW'(effRas + 1)] = mPc + 1;
                mRasIdx = RasDepthW'(effRas + 1);
            end else if (acc && expHit && expKind == BrReturn) begin
                mRasIdx = RasDepthW'(effRas - 1);
            end else begin
                mRasIdx = effRas;
            end
            mHist = (acc && expCond) ? shiftHist(effHist, expTaken) : effHist;
            if (misprAct) begin
                mPc = misprTarget;
                mId = misprId + 1'b1;
            end else if (acc) begin
                mPc = expNext;
                mId = mId + 1'b1;
            end
            tgtFull = mTgtQ.size() == UpdQueueDepth;
            if (mStarted && mTgtQ.size() > 0) begin
                mBtbValid[mTgtQ[0].pc[BtbIdxW-1:0]] = 1'b1;
                mBtbTag[mTgtQ[0].pc[BtbIdxW-1:0]] = mTgtQ[0].pc[BtbIdxW+BtbTagW-1:BtbIdxW];
                mBtbKind[mTgtQ[0].pc[BtbIdxW-1:0]] = mTgtQ[0].kind;
                mBtbTarget[mTgtQ[0].pc[BtbIdxW-1:0]] = mTgtQ[0].target;
                void'(mTgtQ.pop_front());
            end
            if (tgtValid && mStarted && !tgtFull) begin
                mTgtQ.push_back('{pc: tgtPc, target: tgtTarget, kind: tgtKind});
            end
            resFull = mResQ.size() == UpdQueueDepth;
            if (newTrain) begin
                void'(mResQ.pop_front());
            end
            if (resolveValid && !resFull) begin
                mResQ.push_back('{fetchId: resolveId, taken: resolveTaken});
            end
            mRecValid = misprAct;
            mTrainPending = newTrain;
            mStarted = 1'b1;
        end
    end

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic runCycles(input int n, input bit randomReady);
        repeat (n) begin
            fetchReady = randomReady ? (($random(seed) & 3) != 0) : 1'b1;
            stepCycle();
        end
    endtask

    task automatic addTarget(input logic [PcW-1:0] pc, input logic [PcW-1:0] target,
                             input BrKind kind);
        int i;
        tgtValid = 1'b1;
        tgtPc = pc;
        tgtTarget = target;
        tgtKind = kind;
        stepCycle();
        tgtValid = 1'b0;
        for (i = 0; i < 20 && mTgtQ.size() > 0; i++) begin
            stepCycle();
        end
        if (mTgtQ.size() > 0) begin
            timeoutFail("the target update queue to drain");
        end
        stepCycle();
    endtask

    task automatic redirect(input logic [PcW-1:0] target, input logic taken);
        logic [FetchIdW-1:0] id;
        id = lastAcceptId;
        misprValid = 1'b1;
        misprId = id;
        misprTaken = taken;
        misprTarget = target;
        stepCycle();
        misprValid = 1'b0;
        check("fetchPc", fetchPc, target);
        check("fetchId", fetchId, FetchIdW'(id + 1'b1));
    endtask

    task automatic waitFetchOf(input logic [PcW-1:0] pc);
        int i;
        watchPc = pc;
        watchHit = 1'b0;
        fetchReady = 1'b1;
        for (i = 0; i < 100 && !watchHit; i++) begin
            stepCycle();
        end
        if (!watchHit) begin
            timeoutFail("a fetch of the watched address");
        end
        watchPc = '1;
    endtask

    task automatic sendResolve(input logic [FetchIdW-1:0] id, input logic taken);
        int i;
        logic done;
        done = 1'b0;
        resolveValid = 1'b1;
        resolveId = id;
        resolveTaken = taken;
        for (i = 0; i < 50 && !done; i++) begin
            done = resolveReady;
            stepCycle();
        end
        if (!done) begin
            timeoutFail("resolveReady");
        end
        resolveValid = 1'b0;
    endtask

    initial begin
        int i;
        logic [FetchIdW-1:0] stormId;
        rst = 1'b1;
        fetchReady = 1'b0;
        tgtValid = 1'b0;
        tgtPc = '0;
        tgtTarget = '0;
        tgtKind = BrJump;
        resolveValid = 1'b0;
        resolveId = '0;
        resolveTaken = 1'b0;
        misprValid = 1'b0;
        misprId = '0;
        misprTaken = 1'b0;
        misprTarget = '0;
        watchPc = '1;
        watchHit = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        stepCycle();
        check("fetchPc", fetchPc, ResetPc);
        check("fetchId", fetchId, 0);

        // Sequential fetch with random stalls
        runCycles(60, 1'b1);

        // Unconditional jump
        addTarget(30'h201, 30'h300, BrJump);
        redirect(30'h201, 1'b0);
        runCycles(6, 1'b0);

        // Conditional branch trained taken
        addTarget(30'h412, 30'h480, BrCond);
        repeat (3) begin
            redirect(30'h412, 1'b0);
            waitFetchOf(30'h412);
            runCycles(2, 1'b0);
            sendResolve(watchId, 1'b1);
            runCycles(4, 1'b0);
        end
        redirect(30'h412, 1'b0);
        runCycles(6, 1'b0);

        // Nested call and return pairs
        addTarget(30'h523, 30'h636, BrCall);
        addTarget(30'h636, 30'h748, BrCall);
        addTarget(30'h748, 30'h0, BrReturn);
        addTarget(30'h637, 30'h0, BrReturn);
        redirect(30'h523, 1'b0);
        runCycles(10, 1'b0);

        // Mispredicts with random outcomes
        for (i = 0; i < 6; i++) begin
            redirect(30'h412, $random(seed) & 1);
            runCycles(8, 1'b1);
        end

        // Resolve queue fills while mispredicts keep the backup port busy
        redirect(30'h900, 1'b0);
        stormId = lastAcceptId;
        misprValid = 1'b1;
        misprId = stormId;
        misprTarget = 30'h900;
        stepCycle();
        repeat (UpdQueueDepth) begin
            sendResolve(stormId + 1'b1, 1'b1);
        end
        resolveValid = 1'b1;
        resolveId = stormId + 1'b1;
        stepCycle();
        stepCycle();
        check("resolveReady", resolveReady, 0);
        check("fetchValid", fetchValid, 0);
        misprValid = 1'b0;
        sendResolve(stormId + 1'b1, 1'b0);
        for (i = 0; i < 50 && !fetchValid; i++) begin
            stepCycle();
        end
        if (!fetchValid) begin
            timeoutFail("fetchValid after the resolve queue drained");
        end
        check("resolveQueueDepth", mResQ.size(), 0);
        runCycles(20, 1'b1);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog/branchPredictor.sv */
`timescale 1ns/1ps

module branchPredictor import bpPkg::*; (
    input  logic clk,
    input  logic rst,
    output logic fetchValid,
    input  logic fetchReady,
    output logic [PcW-1:0] fetchPc,
    output logic [FetchIdW-1:0] fetchId,
    output logic predTaken,
    output BrKind predKind,
    output logic predHit,
    output logic [PcW-1:0] nextPc,
    input  logic tgtValid,
    input  logic [PcW-1:0] tgtPc,
    input  logic [PcW-1:0] tgtTarget,
    input  BrKind tgtKind,
    input  logic resolveValid,
    output logic resolveReady,
    input  logic [FetchIdW-1:0] resolveId,
    input  logic resolveTaken,
    input  logic misprValid,
    input  logic [FetchIdW-1:0] misprId,
    input  logic misprTaken,
    input  logic [PcW-1:0] misprTarget
);

    logic started;
    logic [PcW-1:0] pcReg;
    logic [FetchIdW-1:0] idReg;
    logic [HistW-1:0] history;
    logic [HistW-1:0] recHist;
    logic [HistW-1:0] effHist;
    logic [HistW-1:0] nextHist;
    logic recValid;
    logic recTaken;
    logic trainPending;
    logic trainTakenReg;
    logic misprAct;
    logic accept;
    logic fetchLimit;

    logic btbHit;
    BrKind btbKind;
    logic [PcW-1:0] btbTarget;
    logic dirTaken;
    logic [PcW-1:0] rasTop;
    logic [RasDepthW-1:0] rasIdx;
    logic isCond;

    TgtUpdRec tgtIn;
    TgtUpdRec tgtHead;
    logic tgtHeadValid;
    ResolveRec resIn;
    ResolveRec resHead;
    logic resHeadValid;
    logic resDeq;

    BackupRec bkWData;
    BackupRec bkRData;
    logic bkRe;
    logic [FetchIdW-1:0] bkRAddr;

    assign fetchPc = pcReg;
    assign fetchId = idReg;
    assign misprAct = misprValid && started;

    // A fetch that collides with a mispredict is dropped
    assign accept = fetchValid && fetchReady && !misprAct;

    // Keep fetch off backup entries still waiting for training
    assign fetchLimit = (resHeadValid && resHead.fetchId == idReg)
        || (resolveValid && resolveId == idReg);
    assign fetchValid = started && !fetchLimit;

    // Saved history, plus the resolved outcome of the branch itself
    assign recHist = bkRData.isCond ? {bkRData.hist[HistW-2:0], recTaken} : bkRData.hist;
    assign effHist = recValid ? recHist : history;

    assign isCond = btbHit && btbKind == BrCond;
    assign nextHist = (accept && isCond) ? {effHist[HistW-2:0], predTaken} : effHist;

    // Next PC selection
    always_comb begin
        predHit = btbHit;
        predKind = btbHit ? btbKind : BrCond;
        predTaken = 1'b0;
        nextPc = pcReg + PcW'(1);
        if (btbHit) begin
            case (btbKind)
                BrReturn: begin
                    predTaken = 1'b1;
                    nextPc = rasTop;
                end
                BrJump, BrCall: begin
                    predTaken = 1'b1;
                    nextPc = btbTarget;
                end
                default: begin
                    predTaken = dirTaken;
                    if (dirTaken) begin
                        nextPc = btbTarget;
                    end
                end
            endcase
        end
    end

    // One backup read per cycle, mispredict first
    always_comb begin
        resDeq = 1'b0;
        bkRe = 1'b0;
        bkRAddr = misprId;
        if (misprAct) begin
            bkRe = 1'b1;
        end else if (started && resHeadValid) begin
            resDeq = 1'b1;
            bkRe = 1'b1;
            bkRAddr = resHead.fetchId;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            pcReg <= ResetPc;
            idReg <= '0;
            history <= '0;
            recValid <= 1'b0;
            trainPending <= 1'b0;
        end else begin
            started <= 1'b1;
            recValid <= misprAct;
            trainPending <= resDeq;
            history <= nextHist;
            if (misprAct) begin
                pcReg <= misprTarget;
                idReg <= misprId + 1'b1;
            end else if (accept) begin
                pcReg <= nextPc;
                idReg <= idReg + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        recTaken <= misprTaken;
        trainTakenReg <= resHead.taken;
    end

    always_comb begin
        bkWData.hist = effHist;
        bkWData.rasIdx = rasIdx;
        bkWData.pc = pcReg;
        bkWData.isCond = isCond;
        bkWData.predTaken = predTaken;
    end

    assign tgtIn = '{pc: tgtPc, target: tgtTarget, kind: tgtKind};
    assign resIn = '{fetchId: resolveId, taken: resolveTaken};

    // Target updates are dropped when this queue is full
    syncFifo #(.T(TgtUpdRec), .Depth(UpdQueueDepth)) i_tgtQueue (
        .clk(clk),
        .rst(rst),
        .inValid(tgtValid && started),
        .inData(tgtIn),
        .inReady(),
        .outValid(tgtHeadValid),
        .outData(tgtHead),
        .outReady(started)
    );

    syncFifo #(.T(ResolveRec), .Depth(UpdQueueDepth)) i_resolveQueue (
        .clk(clk),
        .rst(rst),
        .inValid(resolveValid),
        .inData(resIn),
        .inReady(resolveReady),
        .outValid(resHeadValid),
        .outData(resHead),
        .outReady(resDeq)
    );

    predBackupFile i_backup (
        .clk(clk),
        .we(accept),
        .wAddr(idReg),
        .wData(bkWData),
        .re(bkRe),
        .rAddr(bkRAddr),
        .rData(bkRData)
    );

    branchTargetBuffer i_btb (
        .clk(clk),
        .rst(rst),
        .lookupPc(pcReg),
        .hit(btbHit),
        .hitKind(btbKind),
        .hitTarget(btbTarget),
        .updValid(tgtHeadValid && started),
        .updPc(tgtHead.pc),
        .updTarget(tgtHead.target),
        .updKind(tgtHead.kind)
    );

    // Training uses the PC and history that the original lookup saw
    gshareDirPredictor i_dirPred (
        .clk(clk),
        .rst(rst),
        .predPc(pcReg),
        .predHist(effHist),
        .predTaken(dirTaken),
        .trainValid(trainPending),
        .trainPc(bkRData.pc),
        .trainHist(bkRData.hist),
        .trainTaken(trainTakenReg)
    );

    returnStack i_ras (
        .clk(clk),
        .rst(rst),
        .push(accept && btbHit && btbKind == BrCall),
        .pop(accept && btbHit && btbKind == BrReturn),
        .pushAddr(pcReg + PcW'(1)),
        .top(rasTop),
        .curIdx(rasIdx),
        .restore(recValid),
        .restoreIdx(bkRData.rasIdx)
    );

endmodule

/* verilog/returnStack.sv */
`timescale 1ns/1ps

module returnStack import bpPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    input  logic [PcW-1:0] pushAddr,
    output logic [PcW-1:0] top,
    output logic [RasDepthW-1:0] curIdx,
    input  logic restore,
    input  logic [RasDepthW-1:0] restoreIdx
);

    logic [PcW-1:0] stack [1 << RasDepthW];
    logic [RasDepthW-1:0] idx;
    logic [RasDepthW-1:0] effIdx;

    // A restore replaces the index right away, so the same cycle
    // already predicts from the recovered top
    assign effIdx = restore ? restoreIdx : idx;
    assign curIdx = effIdx;
    assign top = stack[effIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= '0;
        end else if (push) begin
            idx <= effIdx + 1'b1;
        end else if (pop) begin
            idx <= effIdx - 1'b1;
        end else begin
            idx <= effIdx;
        end
    end

    // Index wraps, so the oldest entries get overwritten
    always_ff @(posedge clk) begin
        if (push) begin
            stack[effIdx + 1'b1] <= pushAddr;
        end
    end

endmodule

/* verilog/gshareDirPredictor.sv */
`timescale 1ns/1ps

module gshareDirPredictor import bpPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic [PcW-1:0] predPc,
    input  logic [HistW-1:0] predHist,
    output logic predTaken,
    input  logic trainValid,
    input  logic [PcW-1:0] trainPc,
    input  logic [HistW-1:0] trainHist,
    input  logic trainTaken
);

    logic [1:0] ctr [1 << HistW];
    logic [HistW-1:0] predIdx;
    logic [HistW-1:0] trainIdx;
    logic [1:0] trainCur;

    // gshare hash
    assign predIdx = predPc[HistW-1:0] ^ predHist;
    assign trainIdx = trainPc[HistW-1:0] ^ trainHist;

    assign predTaken = ctr[predIdx][1];
    assign trainCur = ctr[trainIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Weakly not-taken
            for (int i = 0; i < (1 << HistW); i++) begin
                ctr[i] <= 2'b01;
            end
        end else if (trainValid) begin
            if (trainTaken && trainCur != 2'b11) begin
                ctr[trainIdx] <= trainCur + 2'b01;
            end else if (!trainTaken && trainCur != 2'b00) begin
                ctr[trainIdx] <= trainCur - 2'b01;
            end
        end
    end

endmodule

/* verilog/branchTargetBuffer.sv */
`timescale 1ns/1ps

module branchTargetBuffer import bpPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic [PcW-1:0] lookupPc,
    output logic hit,
    output BrKind hitKind,
    output logic [PcW-1:0] hitTarget,
    input  logic updValid,
    input  logic [PcW-1:0] updPc,
    input  logic [PcW-1:0] updTarget,
    input  BrKind updKind
);

    logic validArr [1 << BtbIdxW];
    logic [BtbTagW-1:0] tagArr [1 << BtbIdxW];
    BrKind kindArr [1 << BtbIdxW];
    logic [PcW-1:0] targetArr [1 << BtbIdxW];

    logic [BtbIdxW-1:0] lookupIdx;
    logic [BtbTagW-1:0] lookupTag;
    logic [BtbIdxW-1:0] updIdx;
    logic [BtbTagW-1:0] updTag;

    // Low bits pick the entry, the bits above them form the tag
    assign lookupIdx = lookupPc[BtbIdxW-1:0];
    assign lookupTag = lookupPc[BtbIdxW+BtbTagW-1:BtbIdxW];
    assign updIdx = updPc[BtbIdxW-1:0];
    assign updTag = updPc[BtbIdxW+BtbTagW-1:BtbIdxW];

    assign hit = validArr[lookupIdx] && (tagArr[lookupIdx] == lookupTag);
    assign hitKind = kindArr[lookupIdx];
    assign hitTarget = targetArr[lookupIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << BtbIdxW); i++) begin
                validArr[i] <= 1'b0;
            end
        end else if (updValid) begin
            validArr[updIdx] <= 1'b1;
        end
    end

    // An update simply replaces whatever lived at its index
    always_ff @(posedge clk) begin
        if (updValid) begin
            tagArr[updIdx] <= updTag;
            kindArr[updIdx] <= updKind;
            targetArr[updIdx] <= updTarget;
        end
    end

endmodule

/* verilog/predBackupFile.sv */
`timescale 1ns/1ps

module predBackupFile import bpPkg::*; (
    input  logic clk,
    input  logic we,
    input  logic [FetchIdW-1:0] wAddr,
    input  BackupRec wData,
    input  logic re,
    input  logic [FetchIdW-1:0] rAddr,
    output BackupRec rData
);

    BackupRec mem [1 << FetchIdW];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wAddr] <= wData;
        end
        // Read data shows up the cycle after re
        if (re) begin
            rData <= mem[rAddr];
        end
    end

endmodule

/* verilog/syncFifo.sv */
`timescale 1ns/1ps

module syncFifo #(
    parameter type T = logic,
    parameter int Depth = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  T     inData,
    output logic inReady,
    output logic outValid,
    output T     outData,
    input  logic outReady
);

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    T mem [Depth];
    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [CntW-1:0] count;
    logic doWrite;
    logic doRead;

    assign inReady = (count != CntW'(Depth));
    assign outValid = (count != '0);
    assign outData = mem[rdPtr];

    assign doWrite = inValid && inReady;
    assign doRead = outValid && outReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            // Pointers wrap at the last entry
            if (doWrite) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (doWrite && !doRead) begin
                count <= count + 1'b1;
            end else if (doRead && !doWrite) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= inData;
        end
    end

endmodule

/* verilog/bpPkg.sv */
package bpPkg;

    // Fetch address and fetch ID widths
    localparam int PcW = 30;
    localparam int FetchIdW = 4;

    // Global history length, also the counter index width
    localparam int HistW = 6;

    // Branch target buffer geometry
    localparam int BtbIdxW = 4;
    localparam int BtbTagW = 8;

    // Return stack index width
    localparam int RasDepthW = 3;

    localparam int UpdQueueDepth = 4;

    localparam logic [PcW-1:0] ResetPc = 30'h100;

    typedef enum logic [1:0] {
        BrCond   = 2'd0,
        BrJump   = 2'd1,
        BrCall   = 2'd2,
        BrReturn = 2'd3
    } BrKind;

    // Resolved conditional branch from the back end
    typedef struct packed {
        logic [FetchIdW-1:0] fetchId;
        logic taken;
    } ResolveRec;

    typedef struct packed {
        logic [PcW-1:0] pc;
        logic [PcW-1:0] target;
        BrKind kind;
    } TgtUpdRec;

    // Snapshot taken at every fetch
    typedef struct packed {
        logic [HistW-1:0] hist;
        logic [RasDepthW-1:0] rasIdx;
        logic [PcW-1:0] pc;
        logic isCond;
        logic predTaken;
    } BackupRec;

endpackage
